// ==== Bender.yml ====
package:
  name: vcache_profiler

sources:
  - logic/vcache_prof_pkg.sv
  - logic/vcache_event_classifier.sv
  - logic/vcache_event_fifo.sv
  - logic/vcache_stat_bank.sv
  - logic/vcache_profiler.sv
  - target: test
    files:
      - tb/vcache_profiler_tb.sv

// ==== compile.f ====
logic/vcache_prof_pkg.sv
logic/vcache_event_classifier.sv
logic/vcache_event_fifo.sv
logic/vcache_stat_bank.sv
logic/vcache_profiler.sv
tb/vcache_profiler_tb.sv

// ==== logic/vcache_event_classifier.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cache event classifier: one registered event
// code per enabled cycle, fixed priority
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module vcache_event_classifier (
  input  logic                                    clk_i,
  input  logic                                    reset_i,
  input  logic                                    v_i,        // response valid
  input  logic                                    yumi_i,     // network took it
  input  logic                                    miss_i,     // miss handler busy
  input  logic                                    ld_op_i,
  input  logic                                    st_op_i,
  input  logic                                    mask_op_i,
  input  logic                                    sigext_i,
  input  vcache_prof_pkg::data_size_e             data_size_i,
  input  logic [vcache_prof_pkg::mask_width_c-1:0] mask_i,
  input  logic                                    count_en_i,
  output logic                                    push_v_o,
  output vcache_prof_pkg::stat_id_e               push_id_o
);

  import vcache_prof_pkg::*;

  logic     accepted;
  logic     push_v_r;
  stat_id_e event_id;
  stat_id_e push_id_r;

  assign accepted = v_i & yumi_i;

  always_comb begin
    event_id = stat_idle; // fall-through case
    if (accepted & miss_i & ld_op_i) begin
      event_id = stat_miss_ld;
    end else if (accepted & miss_i & st_op_i) begin
      event_id = stat_miss_st;
    end else if (miss_i) begin
      event_id = stat_miss_busy;
    end else if (accepted & ld_op_i & ~mask_op_i) begin
      unique case (data_size_i)
        size_word: event_id = sigext_i ? stat_ld_lw : stat_ld_lwu;
        size_half: event_id = sigext_i ? stat_ld_lh : stat_ld_lhu;
        size_byte: event_id = sigext_i ? stat_ld_lb : stat_ld_lbu;
        default:   event_id = stat_idle; // double not profiled
      endcase
    end else if (accepted & st_op_i & mask_op_i) begin
      case ($countones(mask_i))
        4:       event_id = stat_sm_sw;
        2:       event_id = stat_sm_sh;
        1:       event_id = stat_sm_sb;
        default: event_id = stat_idle; // odd masks
      endcase
    end else if (v_i & ~yumi_i) begin
      event_id = stat_stall_rsp;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      push_v_r <= 1'b0;
    end else begin
      push_v_r <= count_en_i; // one push per enabled cycle
    end
  end

  always_ff @(posedge clk_i) begin
    push_id_r <= event_id;
  end

  assign push_v_o  = push_v_r;
  assign push_id_o = push_id_r;

endmodule

// ==== logic/vcache_event_fifo.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// event code FIFO with saturating drop counter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module vcache_event_fifo #(
  parameter int fifo_depth_p    = 8,
  parameter int counter_width_p = 32
) (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             push_v_i,
  input  vcache_prof_pkg::stat_id_e        push_id_i,
  input  logic                             pop_yumi_i,
  output logic                             pop_v_o,
  output vcache_prof_pkg::stat_id_e        pop_id_o,
  output logic [counter_width_p-1:0]       drop_count_o
);

  import vcache_prof_pkg::*;

  localparam int ptr_width_lp = $clog2(fifo_depth_p);
  localparam int cnt_width_lp = ptr_width_lp + 1;
  localparam logic [cnt_width_lp-1:0] depth_lp = cnt_width_lp'(fifo_depth_p);

  stat_id_e                   mem_r [fifo_depth_p];
  logic [ptr_width_lp-1:0]    wr_ptr_r;
  logic [ptr_width_lp-1:0]    rd_ptr_r;
  logic [cnt_width_lp-1:0]    count_r;
  logic [counter_width_p-1:0] drop_count_r;
  logic                       full;
  logic                       do_push;
  logic                       do_pop;
  logic                       do_drop;

  assign full    = (count_r == depth_lp);
  assign pop_v_o = (count_r != '0);
  assign do_pop  = pop_yumi_i & pop_v_o;
  assign do_push = push_v_i & (~full | do_pop); // full is fine if head leaves
  assign do_drop = push_v_i & full & ~do_pop;

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_r[wr_ptr_r] <= push_id_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (do_push) wr_ptr_r <= wr_ptr_r + 1'b1; // wraps, depth is 2**n
      if (do_pop)  rd_ptr_r <= rd_ptr_r + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      drop_count_r <= '0;
    end else if (do_drop && drop_count_r != '1) begin
      drop_count_r <= drop_count_r + 1'b1; // saturates at all ones
    end
  end

  assign pop_id_o     = mem_r[rd_ptr_r];
  assign drop_count_o = drop_count_r;

endmodule

// ==== logic/vcache_prof_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// vcache profiler shared definitions: event codes,
// cache access-size codes and counter-bank sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package vcache_prof_pkg;

  // number of counter indices and selector width
  localparam int num_stats_c      = 16;
  localparam int stat_sel_width_c = $clog2(num_stats_c);

  // store byte mask width, 32-bit data
  localparam int mask_width_c = 4;

  // counter indices, one per event class
  typedef enum logic [3:0] {
    stat_ld_lw     = 4'd0,  // load word
    stat_ld_lwu    = 4'd1,  // load word unsigned
    stat_ld_lh     = 4'd2,  // load half
    stat_ld_lhu    = 4'd3,  // load half unsigned
    stat_ld_lb     = 4'd4,  // load byte
    stat_ld_lbu    = 4'd5,  // load byte unsigned
    stat_sm_sw     = 4'd6,  // masked store, 4 bytes
    stat_sm_sh     = 4'd7,  // masked store, 2 bytes
    stat_sm_sb     = 4'd8,  // masked store, 1 byte
    stat_miss_ld   = 4'd9,  // load miss completion
    stat_miss_st   = 4'd10, // store miss completion
    stat_miss_busy = 4'd11, // miss handler active
    stat_stall_rsp = 4'd12, // response held by network
    stat_idle      = 4'd13,
    stat_dropped   = 4'd14, // served from fifo drop counter
    stat_none      = 4'd15  // no event, reads as zero
  } stat_id_e;

  // access size as decoded by the cache
  typedef enum logic [1:0] {
    size_byte   = 2'b00,
    size_half   = 2'b01,
    size_word   = 2'b10,
    size_double = 2'b11
  } data_size_e;

endpackage

// ==== logic/vcache_profiler.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// data cache profiler top: classifier, event FIFO
// and counter bank
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module vcache_profiler #(
  parameter int fifo_depth_p    = 8,
  parameter int counter_width_p = 32
) (
  input  logic                                       clk_i,
  input  logic                                       reset_i,
  input  logic                                       v_i,
  input  logic                                       yumi_i,
  input  logic                                       miss_i,
  input  logic                                       ld_op_i,
  input  logic                                       st_op_i,
  input  logic                                       mask_op_i,
  input  logic                                       sigext_i,
  input  vcache_prof_pkg::data_size_e                data_size_i,
  input  logic [vcache_prof_pkg::mask_width_c-1:0]   mask_i,
  input  logic                                       count_en_i,
  input  logic                                       stat_req_i,
  input  logic [vcache_prof_pkg::stat_sel_width_c-1:0] stat_sel_i,
  output logic                                       stat_ack_o,
  output logic [counter_width_p-1:0]                 stat_data_o
);

  import vcache_prof_pkg::*;

  logic                       push_v;
  stat_id_e                   push_id;
  logic                       pop_v;
  stat_id_e                   pop_id;
  logic                       pop_yumi;
  logic [counter_width_p-1:0] drop_count;

  vcache_event_classifier i_classifier (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .v_i         (v_i),
    .yumi_i      (yumi_i),
    .miss_i      (miss_i),
    .ld_op_i     (ld_op_i),
    .st_op_i     (st_op_i),
    .mask_op_i   (mask_op_i),
    .sigext_i    (sigext_i),
    .data_size_i (data_size_i),
    .mask_i      (mask_i),
    .count_en_i  (count_en_i),
    .push_v_o    (push_v),
    .push_id_o   (push_id)
  );

  vcache_event_fifo #(
    .fifo_depth_p    (fifo_depth_p),
    .counter_width_p (counter_width_p)
  ) i_fifo (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .push_v_i     (push_v),
    .push_id_i    (push_id),
    .pop_yumi_i   (pop_yumi),
    .pop_v_o      (pop_v),
    .pop_id_o     (pop_id),
    .drop_count_o (drop_count)
  );

  vcache_stat_bank #(
    .counter_width_p (counter_width_p)
  ) i_bank (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .pop_v_i      (pop_v),
    .pop_id_i     (pop_id),
    .drop_count_i (drop_count),
    .stat_req_i   (stat_req_i),
    .stat_sel_i   (stat_sel_i),
    .pop_yumi_o   (pop_yumi),
    .stat_ack_o   (stat_ack_o),
    .stat_data_o  (stat_data_o)
  );

endmodule

// ==== logic/vcache_stat_bank.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// per-class event counters and the four-phase
// req/ack counter readout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module vcache_stat_bank #(
  parameter int counter_width_p = 32
) (
  input  logic                                       clk_i,
  input  logic                                       reset_i,
  input  logic                                       pop_v_i,
  input  vcache_prof_pkg::stat_id_e                  pop_id_i,
  input  logic [counter_width_p-1:0]                 drop_count_i,
  input  logic                                       stat_req_i,
  input  logic [vcache_prof_pkg::stat_sel_width_c-1:0] stat_sel_i,
  output logic                                       pop_yumi_o,
  output logic                                       stat_ack_o,
  output logic [counter_width_p-1:0]                 stat_data_o
);

  import vcache_prof_pkg::*;

  // counters cover stat_ld_lw up to stat_idle
  localparam int num_ctr_lp = int'(stat_dropped);

  logic [counter_width_p-1:0] ctr_r [num_ctr_lp];
  logic                       ack_r;
  logic [counter_width_p-1:0] data_r;
  logic [counter_width_p-1:0] sel_value;
  logic                       port_idle;
  logic                       latch_data;

  // freeze counters for the whole handshake
  assign port_idle  = ~stat_req_i & ~ack_r;
  assign pop_yumi_o = pop_v_i & port_idle;
  assign latch_data = stat_req_i & ~ack_r; // ack about to rise

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < num_ctr_lp; i++) begin
        ctr_r[i] <= '0;
      end
    end else if (pop_yumi_o && pop_id_i < stat_dropped) begin
      ctr_r[pop_id_i] <= ctr_r[pop_id_i] + 1'b1;
    end
  end

  always_comb begin
    case (stat_id_e'(stat_sel_i))
      stat_dropped: sel_value = drop_count_i;
      stat_none:    sel_value = '0;
      default:      sel_value = ctr_r[stat_sel_i];
    endcase
  end

  // ack follows req with one cycle of delay both ways
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ack_r <= 1'b0;
    end else begin
      ack_r <= stat_req_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (latch_data) begin
      data_r <= sel_value; // held stable while ack is high
    end
  end

  assign stat_ack_o  = ack_r;
  assign stat_data_o = data_r;

endmodule

// ==== tb/vcache_profiler_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// vcache profiler testbench: event model, readout
// helpers and directed and random tests
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module vcache_profiler_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import vcache_prof_pkg::*;

  localparam int fifo_depth_p  = 8;
  localparam int ack_timeout_c = 20; // cycles per handshake phase

  logic                        clk_i;
  logic                        reset_i;
  logic                        v_i;
  logic                        yumi_i;
  logic                        miss_i;
  logic                        ld_op_i;
  logic                        st_op_i;
  logic                        mask_op_i;
  logic                        sigext_i;
  data_size_e                  data_size_i;
  logic [mask_width_c-1:0]     mask_i;
  logic                        count_en_i;
  logic                        stat_req_i;
  logic [stat_sel_width_c-1:0] stat_sel_i;
  logic                        stat_ack_o;
  logic [31:0]                 stat_data_o;

  int exp_cnt [num_stats_c]; // predicted counter values
  int enabled_cycles;
  int errors;
  int checks;
  int tests_run;
  int tests_failed;

  vcache_profiler #(
    .fifo_depth_p    (fifo_depth_p),
    .counter_width_p (32)
  ) i_dut (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .v_i         (v_i),
    .yumi_i      (yumi_i),
    .miss_i      (miss_i),
    .ld_op_i     (ld_op_i),
    .st_op_i     (st_op_i),
    .mask_op_i   (mask_op_i),
    .sigext_i    (sigext_i),
    .data_size_i (data_size_i),
    .mask_i      (mask_i),
    .count_en_i  (count_en_i),
    .stat_req_i  (stat_req_i),
    .stat_sel_i  (stat_sel_i),
    .stat_ack_o  (stat_ack_o),
    .stat_data_o (stat_data_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  initial begin
    #200_000; // overall limit
    $display("simulation ran past its time limit");
    $display("SOME TESTS FAILED");
    $finish;
  end

  // event class of one monitored cycle by the profiler priority rule
  function automatic int expected_class(input logic v, yumi, miss, ld, st, mop, sx,
                                        input logic [1:0] sz, input logic [3:0] m);
    int id;
    logic acc;
    acc = v & yumi;
    id  = stat_idle;
    if (acc && miss && ld) id = stat_miss_ld;
    else if (acc && miss && st) id = stat_miss_st;
    else if (miss) id = stat_miss_busy;
    else if (acc && ld && !mop) begin
      if (sz == size_word) id = sx ? stat_ld_lw : stat_ld_lwu;
      if (sz == size_half) id = sx ? stat_ld_lh : stat_ld_lhu;
      if (sz == size_byte) id = sx ? stat_ld_lb : stat_ld_lbu;
    end else if (acc && st && mop) begin
      if ($countones(m) == 4) id = stat_sm_sw;
      if ($countones(m) == 2) id = stat_sm_sh;
      if ($countones(m) == 1) id = stat_sm_sb;
    end else if (v && !yumi) id = stat_stall_rsp;
    return id;
  endfunction

  task automatic drive_cycle(input logic v, yumi, miss, ld, st, mop, sx,
                             input logic [1:0] sz, input logic [3:0] m, input logic en);
    @(posedge clk_i);
    v_i         <= v;
    yumi_i      <= yumi;
    miss_i      <= miss;
    ld_op_i     <= ld;
    st_op_i     <= st;
    mask_op_i   <= mop;
    sigext_i    <= sx;
    data_size_i <= data_size_e'(sz);
    mask_i      <= m;
    count_en_i  <= en;
    if (en) begin
      exp_cnt[expected_class(v, yumi, miss, ld, st, mop, sx, sz, m)]++;
      enabled_cycles++;
    end
  endtask

  task automatic drain();
    drive_cycle(0, 0, 0, 0, 0, 0, 0, 2'b00, 4'h0, 0);
    repeat (fifo_depth_p + 3) @(posedge clk_i);
  endtask

  task automatic check_value(input string name, input int expected, input logic [31:0] actual);
    checks++;
    assert (actual === expected[31:0]) else begin
      $display("[ERROR] %0t %s expected %0d actual %0d", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic wait_ack(input logic level);
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (stat_ack_o !== level && cycles < ack_timeout_c) begin
      @(negedge clk_i);
      cycles++;
    end
    assert (stat_ack_o === level) else begin
      $display("stat_ack_o did not reach %0b within %0d cycles", level, ack_timeout_c);
      errors++;
    end
  endtask

  task automatic read_stat(input int sel, output logic [31:0] value);
    @(posedge clk_i);
    stat_sel_i <= sel[3:0];
    stat_req_i <= 1'b1;
    wait_ack(1'b1);
    value = stat_data_o; // stable while ack is high
    @(posedge clk_i);
    stat_req_i <= 1'b0;
    wait_ack(1'b0);
  endtask

  task automatic check_all_stats();
    logic [31:0] value;
    for (int i = 0; i < num_stats_c; i++) begin
      read_stat(i, value);
      check_value($sformatf("stat_data_o (sel %0d)", i), exp_cnt[i], value);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (errors > errors_before) begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, errors - errors_before);
    end else begin
      $display("%s: ok", name);
    end
  endtask

  task automatic test_reset();
    int start;
    start = errors;
    @(negedge clk_i);
    check_value("stat_ack_o", 0, stat_ack_o);
    check_all_stats(); // model is all zero here
    report_test("reset", start);
  endtask

  task automatic test_loads();
    int start;
    logic [1:0] sizes [3];
    start = errors;
    sizes = '{size_word, size_half, size_byte};
    for (int s = 0; s < 3; s++) begin
      for (int n = 0; n < 2 * s + 1; n++) begin
        drive_cycle(1, 1, 0, 1, 0, 0, 1, sizes[s], 4'h0, 1);
      end
      for (int n = 0; n < 2 * s + 2; n++) begin
        drive_cycle(1, 1, 0, 1, 0, 0, 0, sizes[s], 4'h0, 1);
      end
    end
    repeat (3) drive_cycle(1, 1, 0, 1, 0, 0, 1, size_double, 4'h0, 1); // land in idle
    drain();
    check_all_stats();
    report_test("directed loads", start);
  endtask

  task automatic test_stores();
    int start;
    start = errors;
    repeat (2) drive_cycle(1, 1, 0, 0, 1, 1, 0, size_byte, 4'b0100, 1);
    repeat (4) drive_cycle(1, 1, 0, 0, 1, 1, 0, size_half, 4'b1100, 1);
    repeat (5) drive_cycle(1, 1, 0, 0, 1, 1, 0, size_word, 4'b1111, 1);
    repeat (6) drive_cycle(1, 1, 1, 1, 0, 0, 1, size_word, 4'h0, 1); // load miss done
    repeat (7) drive_cycle(1, 1, 1, 0, 1, 1, 0, size_word, 4'hf, 1); // store miss done
    repeat (8) drive_cycle(0, 0, 1, 0, 0, 0, 0, size_word, 4'h0, 1); // miss busy
    repeat (9) drive_cycle(1, 0, 0, 1, 0, 0, 1, size_half, 4'h0, 1); // stall
    drain();
    check_all_stats();
    report_test("directed stores and misses", start);
  endtask

  task automatic test_count_enable();
    int start;
    start = errors;
    repeat (5) drive_cycle(1, 1, 0, 1, 0, 0, 1, size_word, 4'h0, 0);
    repeat (5) drive_cycle(1, 1, 0, 0, 1, 1, 0, size_byte, 4'b0001, 0);
    repeat (5) drive_cycle(0, 0, 1, 0, 0, 0, 0, size_byte, 4'h0, 0);
    drain();
    check_all_stats();
    report_test("count enable", start);
  endtask

  task automatic test_random();
    int start;
    int op;
    start = errors;
    for (int n = 0; n < 300; n++) begin
      op = $urandom_range(2, 0); // 0 none, 1 load, 2 store
      drive_cycle($urandom_range(1, 0), $urandom_range(1, 0), $urandom_range(3, 0) == 0,
                  op == 1, op == 2, $urandom_range(1, 0), $urandom_range(1, 0),
                  $urandom_range(3, 0), $urandom_range(15, 0), 1);
    end
    drain();
    check_all_stats(); // stat_dropped is expected zero
    report_test("random stream", start);
  endtask

  task automatic test_overflow();
    int start;
    int sum;
    logic [31:0] value;
    start = errors;
    @(posedge clk_i);
    stat_sel_i <= stat_idle;
    stat_req_i <= 1'b1; // freeze the bank
    for (int n = 0; n < 5 * fifo_depth_p; n++) begin
      drive_cycle(1, $urandom_range(1, 0), 0, 1, 0, 0, 1, size_word, 4'h0, 1);
    end
    drive_cycle(0, 0, 0, 0, 0, 0, 0, 2'b00, 4'h0, 0);
    wait_ack(1'b1);
    @(posedge clk_i);
    stat_req_i <= 1'b0;
    wait_ack(1'b0);
    drain();
    sum = 0;
    for (int i = 0; i < int'(stat_dropped); i++) begin
      read_stat(i, value);
      sum += value;
    end
    read_stat(stat_dropped, value);
    check_value("events plus stat_dropped", enabled_cycles, sum + value);
    checks++;
    assert (value != 0) else begin
      $display("no event was dropped although the freeze outlasted the FIFO");
      errors++;
    end
    report_test("overflow under freeze", start);
  endtask

  initial begin
    void'($urandom(32'hfda3)); // seed the thread's generator once
    reset_i        <= 1'b1;
    count_en_i     <= 1'b0;
    stat_req_i     <= 1'b0;
    stat_sel_i     <= '0;
    {v_i, yumi_i, miss_i, ld_op_i, st_op_i, mask_op_i, sigext_i} <= '0;
    data_size_i    <= size_byte;
    mask_i         <= '0;
    foreach (exp_cnt[i]) exp_cnt[i] = 0;
    enabled_cycles = 0;
    errors         = 0;
    checks         = 0;
    tests_run      = 0;
    tests_failed   = 0;
    repeat (4) @(posedge clk_i);
    reset_i <= 1'b0;
    test_reset();
    test_loads();
    test_stores();
    test_count_enable();
    test_random();
    test_overflow();
    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
